//--- hw/ahb_matrix_pkg.sv
`default_nettype none

package ahb_matrix_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // HTRANS codes, upper bit set means an active transfer
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    // RAM depths in words
    localparam int BOOT_RAM_WORDS = 256;
    localparam int MAIN_RAM_WORDS = 1024;

    // Physical address bits 28..22
    localparam logic [6:0] BOOT_MATCH = 7'h7f; // 0x1fc00000
    localparam logic [6:0] GPIO_MATCH = 7'h7e; // 0x1f800000

    // GPIO register map, word offsets
    localparam logic [1:0] GPIO_REG_SWITCHES = 2'd0;
    localparam logic [1:0] GPIO_REG_BUTTONS  = 2'd1;
    localparam logic [1:0] GPIO_REG_LEDS     = 2'd2;

    // GPIO pin widths
    localparam int SWITCH_W = 18;
    localparam int BUTTON_W = 5;
    localparam int LED_W    = 16;

    // Boot RAM, main RAM, GPIO
    localparam int N_SLAVES = 3;

    // Two readings of the same address word
    typedef union packed {
        struct packed {
            logic [9:0]  region;
            logic [19:0] word;     // Word index
            logic [1:0]  byte_off;
        } mem;
        struct packed {
            logic [9:0]  region;
            logic [17:0] unused;
            logic [1:0]  reg_idx;  // Register index
            logic [1:0]  byte_off;
        } io;
    } ahb_addr_u;

endpackage

`default_nettype wire

//--- hw/ahb_addr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module ahb_addr_decoder (
    input  logic [ahb_matrix_pkg::ADDR_W-1:0] HADDR,
    output logic                              sel_boot,
    output logic                              sel_main,
    output logic                              sel_gpio,
    output logic                              sel_none
);
    import ahb_matrix_pkg::*;

    logic [6:0] phys_region;

    // Virtual kseg bits 31..29 are ignored, decode on physical bits only
    assign phys_region = HADDR[28:22];

    // Boot RAM at 0xbfc00000, physical 0x1fc00000
    assign sel_boot = (phys_region == BOOT_MATCH);

    // GPIO at 0xbf800000, physical 0x1f800000
    assign sel_gpio = (phys_region == GPIO_MATCH);

    // Main RAM covers the whole low physical half
    assign sel_main = ~HADDR[28];

    // Whatever is left goes to the default slave
    assign sel_none = ~(sel_boot | sel_gpio | sel_main);

endmodule

`default_nettype wire

//--- hw/ahb_ram_slave.sv
`timescale 1ns/1ns
`default_nettype none

module ahb_ram_slave #(
    parameter int WORDS = ahb_matrix_pkg::MAIN_RAM_WORDS
) (
    input  logic                              HCLK,
    input  logic                              arst_n,
    input  logic                              sel,
    input  logic                              hready_in,
    input  logic [ahb_matrix_pkg::ADDR_W-1:0] HADDR,
    input  logic [1:0]                        HTRANS,
    input  logic                              HWRITE,
    input  logic [2:0]                        HSIZE,
    input  logic [ahb_matrix_pkg::DATA_W-1:0] HWDATA,
    output logic [ahb_matrix_pkg::DATA_W-1:0] rdata,
    output logic                              resp
);
    import ahb_matrix_pkg::*;

    localparam int IDX_W = $clog2(WORDS);

    ahb_addr_u        addr;
    logic             accept;

    // Data-phase control
    logic             dp_we;
    logic [IDX_W-1:0] dp_idx;
    logic [2:0]       dp_size;
    logic [1:0]       dp_off;
    logic [3:0]       dp_be;

    logic [DATA_W-1:0] mem [WORDS];

    assign addr   = HADDR;
    assign accept = sel & HTRANS[1] & hready_in;

    // Write pending for the next data phase
    always_ff @(posedge HCLK or negedge arst_n) begin
        if (!arst_n) begin
            dp_we <= 1'b0;
        end else if (hready_in) begin
            dp_we <= accept & HWRITE;
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            dp_idx  <= addr.mem.word[IDX_W-1:0]; // Wraps modulo WORDS
            dp_size <= HSIZE;
            dp_off  <= addr.mem.byte_off;
        end
    end

    // Byte lanes, little endian
    always_comb begin
        case (dp_size)
            3'b000:  dp_be = 4'b0001 << dp_off;
            3'b001:  dp_be = dp_off[1] ? 4'b1100 : 4'b0011;
            default: dp_be = 4'b1111;
        endcase
    end

    // Merge written lanes at the edge that closes the data phase
    always_ff @(posedge HCLK) begin
        if (dp_we && hready_in) begin
            for (int i = 0; i < 4; i++) begin
                if (dp_be[i]) begin
                    mem[dp_idx][8*i +: 8] <= HWDATA[8*i +: 8];
                end
            end
        end
    end

    // Whole word back, master picks its lanes
    assign rdata = mem[dp_idx];

    assign resp = 1'b0; // Always OKAY

endmodule

`default_nettype wire

//--- hw/ahb_gpio_slave.sv
`timescale 1ns/1ns
`default_nettype none

module ahb_gpio_slave (
    input  logic                                HCLK,
    input  logic                                arst_n,
    input  logic                                sel,
    input  logic                                hready_in,
    input  logic [ahb_matrix_pkg::ADDR_W-1:0]   HADDR,
    input  logic [1:0]                          HTRANS,
    input  logic                                HWRITE,
    input  logic [ahb_matrix_pkg::DATA_W-1:0]   HWDATA,
    input  logic [ahb_matrix_pkg::SWITCH_W-1:0] switches,
    input  logic [ahb_matrix_pkg::BUTTON_W-1:0] buttons,
    output logic [ahb_matrix_pkg::DATA_W-1:0]   rdata,
    output logic                                resp,
    output logic [ahb_matrix_pkg::LED_W-1:0]    leds
);
    import ahb_matrix_pkg::*;

    ahb_addr_u  addr;
    logic       accept;
    logic       dp_we;
    logic [1:0] dp_reg;

    assign addr   = HADDR;
    assign accept = sel & HTRANS[1] & hready_in;

    always_ff @(posedge HCLK or negedge arst_n) begin
        if (!arst_n) begin
            dp_we <= 1'b0;
        end else if (hready_in) begin
            dp_we <= accept & HWRITE;
        end
    end

    // Register index of the current data phase
    always_ff @(posedge HCLK) begin
        if (accept) begin
            dp_reg <= addr.io.reg_idx;
        end
    end

    // LED register, only word 2 is writable
    always_ff @(posedge HCLK or negedge arst_n) begin
        if (!arst_n) begin
            leds <= '0;
        end else if (dp_we && hready_in && dp_reg == GPIO_REG_LEDS) begin
            leds <= HWDATA[LED_W-1:0];
        end
    end

    // Pins are sampled live during the data phase
    always_comb begin
        rdata = '0;
        case (dp_reg)
            GPIO_REG_SWITCHES: rdata[SWITCH_W-1:0] = switches;
            GPIO_REG_BUTTONS:  rdata[BUTTON_W-1:0] = buttons;
            GPIO_REG_LEDS:     rdata[LED_W-1:0]    = leds;
            default:           rdata = '0;          // Register 3 reads zero
        endcase
    end

    assign resp = 1'b0;

endmodule

`default_nettype wire

//--- hw/ahb_response_mux.sv
`timescale 1ns/1ns
`default_nettype none

module ahb_response_mux (
    input  logic                              HCLK,
    input  logic                              arst_n,
    input  logic                              sel_boot,
    input  logic                              sel_main,
    input  logic                              sel_gpio,
    input  logic                              sel_none,
    input  logic [1:0]                        HTRANS,
    input  logic [ahb_matrix_pkg::DATA_W-1:0] boot_rdata,
    input  logic [ahb_matrix_pkg::DATA_W-1:0] main_rdata,
    input  logic [ahb_matrix_pkg::DATA_W-1:0] gpio_rdata,
    input  logic                              boot_resp,
    input  logic                              main_resp,
    input  logic                              gpio_resp,
    output logic [ahb_matrix_pkg::DATA_W-1:0] HRDATA,
    output logic                              HRESP,
    output logic                              HREADY
);
    import ahb_matrix_pkg::*;

    logic                accept;
    logic [N_SLAVES-1:0] dp_sel;    // {gpio, main, boot}
    logic                err_first; // Default slave FSM, ERR1
    logic                err_last;  // ERR2
    logic                slave_resp;

    assign accept = HTRANS[1] & HREADY;

    always_ff @(posedge HCLK or negedge arst_n) begin
        if (!arst_n) begin
            dp_sel    <= '0;
            err_first <= 1'b0;
            err_last  <= 1'b0;
        end else if (HREADY) begin
            dp_sel    <= accept ? {sel_gpio, sel_main, sel_boot} : '0;
            err_first <= accept & sel_none;
            err_last  <= 1'b0;
        end else begin
            // Wait cycle of the error, second cycle follows
            err_first <= 1'b0;
            err_last  <= 1'b1;
        end
    end

    always_comb begin
        HRDATA     = '0;
        slave_resp = 1'b0;
        case (dp_sel)
            3'b001: begin
                HRDATA     = boot_rdata;
                slave_resp = boot_resp;
            end
            3'b010: begin
                HRDATA     = main_rdata;
                slave_resp = main_resp;
            end
            3'b100: begin
                HRDATA     = gpio_rdata;
                slave_resp = gpio_resp;
            end
            default: begin
                HRDATA     = '0; // Idle or error data phase
                slave_resp = 1'b0;
            end
        endcase
    end

    assign HREADY = ~err_first;
    assign HRESP  = err_first | err_last | slave_resp;

endmodule

`default_nettype wire

//--- hw/ahb_lite_matrix.sv
`timescale 1ns/1ns
`default_nettype none

module ahb_lite_matrix (
    input  logic                                HCLK,
    input  logic                                arst_n,
    input  logic [ahb_matrix_pkg::ADDR_W-1:0]   HADDR,
    input  logic [1:0]                          HTRANS,
    input  logic                                HWRITE,
    input  logic [2:0]                          HSIZE,
    input  logic [ahb_matrix_pkg::DATA_W-1:0]   HWDATA,
    output logic [ahb_matrix_pkg::DATA_W-1:0]   HRDATA,
    output logic                                HREADY,
    output logic                                HRESP,
    input  logic [ahb_matrix_pkg::SWITCH_W-1:0] switches,
    input  logic [ahb_matrix_pkg::BUTTON_W-1:0] buttons,
    output logic [ahb_matrix_pkg::LED_W-1:0]    leds
);
    import ahb_matrix_pkg::*;

    logic sel_boot;
    logic sel_main;
    logic sel_gpio;
    logic sel_none;

    logic [DATA_W-1:0] boot_rdata;
    logic [DATA_W-1:0] main_rdata;
    logic [DATA_W-1:0] gpio_rdata;
    logic              boot_resp;
    logic              main_resp;
    logic              gpio_resp;

    ahb_addr_decoder decode (
        .HADDR    (HADDR),
        .sel_boot (sel_boot),
        .sel_main (sel_main),
        .sel_gpio (sel_gpio),
        .sel_none (sel_none)
    );

    ahb_ram_slave #(.WORDS(BOOT_RAM_WORDS)) boot_ram (
        .HCLK      (HCLK),
        .arst_n    (arst_n),
        .sel       (sel_boot),
        .hready_in (HREADY),
        .HADDR     (HADDR),
        .HTRANS    (HTRANS),
        .HWRITE    (HWRITE),
        .HSIZE     (HSIZE),
        .HWDATA    (HWDATA),
        .rdata     (boot_rdata),
        .resp      (boot_resp)
    );

    ahb_ram_slave #(.WORDS(MAIN_RAM_WORDS)) main_ram (
        .HCLK      (HCLK),
        .arst_n    (arst_n),
        .sel       (sel_main),
        .hready_in (HREADY),
        .HADDR     (HADDR),
        .HTRANS    (HTRANS),
        .HWRITE    (HWRITE),
        .HSIZE     (HSIZE),
        .HWDATA    (HWDATA),
        .rdata     (main_rdata),
        .resp      (main_resp)
    );

    ahb_gpio_slave gpio (
        .HCLK      (HCLK),
        .arst_n    (arst_n),
        .sel       (sel_gpio),
        .hready_in (HREADY),
        .HADDR     (HADDR),
        .HTRANS    (HTRANS),
        .HWRITE    (HWRITE),
        .HWDATA    (HWDATA),
        .switches  (switches),
        .buttons   (buttons),
        .rdata     (gpio_rdata),
        .resp      (gpio_resp),
        .leds      (leds)
    );

    // Also owns the default slave for unmapped space
    ahb_response_mux result (
        .HCLK       (HCLK),
        .arst_n     (arst_n),
        .sel_boot   (sel_boot),
        .sel_main   (sel_main),
        .sel_gpio   (sel_gpio),
        .sel_none   (sel_none),
        .HTRANS     (HTRANS),
        .boot_rdata (boot_rdata),
        .main_rdata (main_rdata),
        .gpio_rdata (gpio_rdata),
        .boot_resp  (boot_resp),
        .main_resp  (main_resp),
        .gpio_resp  (gpio_resp),
        .HRDATA     (HRDATA),
        .HRESP      (HRESP),
        .HREADY     (HREADY)
    );

endmodule

`default_nettype wire

//--- sim/ahb_matrix_chk.sv
`timescale 1ns/1ns
`default_nettype none

module ahb_matrix_chk (
    input logic        HCLK,
    input logic        arst_n,
    input logic [1:0]  HTRANS,
    input logic        HWRITE,
    input logic        HREADY,
    input logic        HRESP,
    input logic [15:0] leds
);

    // Idle response while reset is held
    reset_okay: assert property (@(posedge HCLK) !arst_n |-> (HREADY && !HRESP))
        else $error("bus not idle in reset");

    // ERR1 always moves on to ERR2
    error_second: assert property (@(posedge HCLK) disable iff (!arst_n)
        (!HREADY && HRESP) |=> (HREADY && HRESP))
        else $error("error response not completed");

    error_first: assert property (@(posedge HCLK) disable iff (!arst_n)
        (HREADY && HRESP) |-> $past(!HREADY && HRESP))
        else $error("error response without a wait cycle");

    // New value is seen two samples after the write address phase
    leds_write: assert property (@(posedge HCLK) disable iff (!arst_n)
        $changed(leds) |-> $past(HTRANS[1] && HWRITE && HREADY, 2))
        else $error("leds changed without a write");

endmodule

bind ahb_lite_matrix ahb_matrix_chk chk (
    .HCLK   (HCLK),
    .arst_n (arst_n),
    .HTRANS (HTRANS),
    .HWRITE (HWRITE),
    .HREADY (HREADY),
    .HRESP  (HRESP),
    .leds   (leds)
);

`default_nettype wire

//--- sim/tb_ahb_lite_matrix.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ahb_lite_matrix;

    localparam int PERIOD   = 100;
    localparam int N_RANDOM = 300;
    localparam int N_XFERS  = N_RANDOM + 80; // Directed transfers included
    localparam int K_IDLE   = 0;
    localparam int K_BOOT   = 1;
    localparam int K_MAIN   = 2;
    localparam int K_GPIO   = 3;
    localparam int K_NONE   = 4;

    logic        HCLK;
    logic        arst_n;
    logic [31:0] HADDR;
    logic [1:0]  HTRANS;
    logic        HWRITE;
    logic [2:0]  HSIZE;
    logic [31:0] HWDATA;
    logic [31:0] HRDATA;
    logic        HREADY;
    logic        HRESP;
    logic [17:0] switches;
    logic [4:0]  buttons;
    logic [15:0] leds;

    // Reference model
    logic [31:0] boot_mem [256];
    logic [31:0] main_mem [1024];
    logic        boot_ok [256];
    logic        main_ok [1024];
    logic [15:0] led_model;

    // Transfer whose data phase is in progress
    int          p_kind;
    logic [31:0] p_addr;
    logic        p_write;
    logic [2:0]  p_size;
    logic [31:0] p_wdata;

    int          errors;
    int          checks;
    integer      seed;

    ahb_lite_matrix UUT (
        .HCLK     (HCLK),
        .arst_n   (arst_n),
        .HADDR    (HADDR),
        .HTRANS   (HTRANS),
        .HWRITE   (HWRITE),
        .HSIZE    (HSIZE),
        .HWDATA   (HWDATA),
        .HRDATA   (HRDATA),
        .HREADY   (HREADY),
        .HRESP    (HRESP),
        .switches (switches),
        .buttons  (buttons),
        .leds     (leds)
    );

    initial begin
        HCLK = 1'b0;
        forever #(PERIOD / 2) HCLK = ~HCLK;
    end

    initial begin
        #(N_XFERS * 3 * PERIOD + 4 * PERIOD);
        $display("Timeout: the transfers did not finish in the expected time");
        $display("Simulation failed");
        $finish;
    end

    // Address map as seen from the master
    function automatic int region_of(input logic [31:0] a);
        if (!a[28]) return K_MAIN;
        if (a[28:22] == 7'h7f) return K_BOOT;
        if (a[28:22] == 7'h7e) return K_GPIO;
        return K_NONE;
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wd,
                                                input logic [2:0] size, input logic [1:0] off);
        logic [31:0] m;
        int          nbytes;
        m = old;
        nbytes = 1 << size;
        for (int i = 0; i < 4; i++) begin
            if (i >= int'(off) && i < int'(off) + nbytes) m[8*i +: 8] = wd[8*i +: 8];
        end
        return m;
    endfunction

    function automatic logic [31:0] expected_read(input int kind, input logic [31:0] a);
        case (kind)
            K_BOOT: return boot_mem[a[9:2]];
            K_MAIN: return main_mem[a[11:2]]; // 1024 words wrap
            K_GPIO: begin
                case (a[3:2])
                    2'd0:    return {14'b0, switches};
                    2'd1:    return {27'b0, buttons};
                    2'd2:    return {16'b0, led_model};
                    default: return 32'b0;
                endcase
            end
            default: return 32'b0;
        endcase
    endfunction

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("FAILED at %0t ns: %s", $time, msg);
            errors++;
        end
    endtask

    // Checks the data phase under way and drives its write data
    task automatic close_phase();
        logic [31:0] exp;
        if (p_kind == K_NONE) begin
            check(HREADY === 1'b0 && HRESP === 1'b1, "first error cycle wrong");
            return;
        end
        check(HREADY === 1'b1 && HRESP === 1'b0, $sformatf("bad response at %h", p_addr));
        if (!p_write) begin
            exp = expected_read(p_kind, p_addr);
            check(HRDATA === exp, $sformatf("read %h got %h expected %h", p_addr, HRDATA, exp));
            return;
        end
        HWDATA = p_wdata;
        case (p_kind)
            K_BOOT: boot_mem[p_addr[9:2]] =
                merge_lanes(boot_mem[p_addr[9:2]], p_wdata, p_size, p_addr[1:0]);
            K_MAIN: main_mem[p_addr[11:2]] =
                merge_lanes(main_mem[p_addr[11:2]], p_wdata, p_size, p_addr[1:0]);
            K_GPIO: if (p_addr[3:2] == 2'd2) led_model = p_wdata[15:0];
            default: ;
        endcase
    endtask

    // One pipelined transfer, address phase here, data phase in the next call
    task automatic xfer(input bit active, input logic [31:0] addr, input bit write,
                        input logic [2:0] size, input logic [31:0] wdata);
        @(negedge HCLK);
        check(leds === led_model, $sformatf("leds %h expected %h", leds, led_model));
        close_phase();
        HADDR  = addr;
        HTRANS = active ? 2'b10 : 2'b00;
        HWRITE = write;
        HSIZE  = size;
        if (p_kind == K_NONE) begin
            @(negedge HCLK); // Address held through the wait state
            check(HREADY === 1'b1 && HRESP === 1'b1, "second error cycle wrong");
        end
        p_kind  = active ? region_of(addr) : K_IDLE;
        p_addr  = addr;
        p_write = write;
        p_size  = size;
        p_wdata = wdata;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        xfer(1'b1, addr, 1'b1, 3'd2, data);
    endtask

    task automatic read_word(input logic [31:0] addr);
        xfer(1'b1, addr, 1'b0, 3'd2, 32'b0);
    endtask

    task automatic random_xfer();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] wd;
        logic [2:0]  size;
        logic [1:0]  off;
        logic        wr;
        r    = $random(seed);
        a    = $random(seed);
        wd   = $random(seed);
        wr   = r[3];
        size = (r[5:4] == 2'd3) ? 3'd2 : {1'b0, r[5:4]};
        off  = a[1:0] & ((size == 3'd0) ? 2'b11 : (size == 3'd1) ? 2'b10 : 2'b00);
        case (r[2:0])
            3'd0: xfer(1'b0, a, 1'b0, 3'd2, wd);
            3'd1, 3'd2: begin
                if (!boot_ok[a[9:2]]) begin
                    wr   = 1'b1; // Unknown word, fill it first
                    size = 3'd2;
                    off  = 2'b00;
                end
                if (wr && size == 3'd2) boot_ok[a[9:2]] = 1'b1;
                xfer(1'b1, 32'hbfc0_0000 | {22'b0, a[9:2], off}, wr, size, wd);
            end
            3'd5: xfer(1'b1, 32'hbf80_0000 | {28'b0, a[3:2], 2'b00}, wr, 3'd2, wd);
            3'd6: xfer(1'b1, 32'h9000_0000 | {16'b0, a[15:2], 2'b00}, wr, 3'd2, wd);
            default: begin
                if (!main_ok[a[11:2]]) begin
                    wr   = 1'b1;
                    size = 3'd2;
                    off  = 2'b00;
                end
                if (wr && size == 3'd2) main_ok[a[11:2]] = 1'b1;
                xfer(1'b1, 32'h8000_0000 | {16'b0, a[15:2], off}, wr, size, wd);
            end
        endcase
    endtask

    initial begin
        arst_n    = 1'b0;
        HADDR     = 32'b0;
        HTRANS    = 2'b00;
        HWRITE    = 1'b0;
        HSIZE     = 3'd2;
        HWDATA    = 32'b0;
        switches  = 18'b0;
        buttons   = 5'b0;
        led_model = 16'b0;
        p_kind    = K_IDLE;
        p_addr    = 32'b0;
        p_write   = 1'b0;
        p_size    = 3'd2;
        p_wdata   = 32'b0;
        errors    = 0;
        checks    = 0;
        seed      = 32'h7878_468e;
        for (int i = 0; i < 256; i++) boot_ok[i] = 1'b0;
        for (int i = 0; i < 1024; i++) main_ok[i] = 1'b0;
        repeat (4) @(posedge HCLK);
        @(negedge HCLK);
        arst_n = 1'b1;

        for (int i = 0; i < 6; i++) write_word(32'hbfc0_0000 + 4 * i, 32'hb007_0000 + i);
        for (int i = 0; i < 6; i++) read_word(32'hbfc0_0000 + 4 * i);
        write_word(32'hbfc0_0040, 32'hcafe_f00d);
        read_word(32'hbfc0_0040); // Straight after the write
        for (int i = 0; i < 4; i++) write_word(32'h8000_0000 + 4 * i, ~i);
        for (int i = 0; i < 4; i++) read_word(32'h8000_0000 + 4 * i);
        write_word(32'h8000_0100, 32'h1122_3344);
        read_word(32'h8000_0100);
        for (int i = 0; i < 6; i++) boot_ok[i] = 1'b1;
        for (int i = 0; i < 4; i++) main_ok[i] = 1'b1;
        boot_ok[16] = 1'b1;
        main_ok[64] = 1'b1;

        xfer(1'b1, 32'h8000_0101, 1'b1, 3'd0, 32'h0000_aa00);
        xfer(1'b1, 32'h8000_0102, 1'b1, 3'd1, 32'hbeef_0000);
        read_word(32'h8000_0100);
        xfer(1'b1, 32'h8000_0100, 1'b1, 3'd1, 32'h0000_5a5a);
        read_word(32'h8000_0100);

        switches = 18'h2a5c3;
        buttons  = 5'h15;
        read_word(32'hbf80_0000);
        read_word(32'hbf80_0004);
        write_word(32'hbf80_0008, 32'h1234_a5c3);
        read_word(32'hbf80_0008);
        write_word(32'hbf80_0000, 32'hffff_ffff); // Read-only register
        read_word(32'hbf80_000c);

        write_word(32'h9000_0008, 32'hdead_beef);
        read_word(32'h9000_0004);
        read_word(32'h8000_0008); // Words a stray write would hit
        read_word(32'hbfc0_0008);
        read_word(32'hbf80_0008);

        for (int n = 0; n < N_RANDOM; n++) random_xfer();
        xfer(1'b0, 32'b0, 1'b0, 3'd2, 32'b0);
        xfer(1'b0, 32'b0, 1'b0, 3'd2, 32'b0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hw/ahb_matrix_pkg.sv
hw/ahb_addr_decoder.sv
hw/ahb_ram_slave.sv
hw/ahb_gpio_slave.sv
hw/ahb_response_mux.sv
hw/ahb_lite_matrix.sv
sim/ahb_matrix_chk.sv
sim/tb_ahb_lite_matrix.sv

//--- Makefile
TOP = tb_ahb_lite_matrix

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
